// ==== hdl/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// RV32I word width
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_NREGS 32

// Bits needed to name one register
`define RV_REG_AW 5

`endif

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

`include "rv_defines.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    typedef logic [`RV_XLEN-1:0]   instr_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            funct7_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    // ALU funct3 for OP and OP_IMM
    localparam funct3_t F3_ADD  = 3'b000;   // ADD, SUB
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;   // SRL, SRA
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// ==== hdl/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_ctrl_e;

    // Writeback mux select
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } branch_e;

    typedef enum logic [1:0] {
        UP_NONE  = 2'd0,
        UP_LUI   = 2'd1,
        UP_AUIPC = 2'd2
    } upper_op_e;

    typedef logic [2:0] mem_op_t;   // Load/store funct3, size and sign

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        logic        jump;
        branch_e     branch;
        alu_ctrl_e   alu_ctrl;
        logic        alu_src;
        upper_op_e   upper_op;
        mem_op_t     mem_op;
    } ctrl_t;

    // Decode to execute bundle
    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rd1;
        word_t     rd2;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm_ext;
        word_t     pc_plus4;
    } de_stage_t;

endpackage

`default_nettype wire

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  instr_t instr_i,
    output ctrl_t  ctrl_o
);

    opcode_e opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // alt is funct7[5]; reg_op lets it pick SUB as well as SRA
    function automatic alu_ctrl_e alu_decode(
        input funct3_t f3,
        input logic    alt,
        input logic    reg_op
    );
        alu_ctrl_e op;
        op = ALU_ADD;
        case (f3)
            F3_ADD:  op = (reg_op && alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    function automatic branch_e branch_decode(input funct3_t f3);
        branch_e br;
        case (f3)
            F3_BEQ:  br = BR_EQ;
            F3_BNE:  br = BR_NE;
            F3_BLT:  br = BR_LT;
            F3_BGE:  br = BR_GE;
            F3_BLTU: br = BR_LTU;
            F3_BGEU: br = BR_GEU;
            default: br = BR_NONE;   // 010 and 011 are reserved
        endcase
        return br;
    endfunction

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            OP: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_ctrl  = alu_decode(funct3, funct7[5], 1'b1);
            end
            OP_IMM: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_ctrl  = alu_decode(funct3, funct7[5], 1'b0);
            end
            LOAD: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.result_src = RES_MEM;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.alu_ctrl   = ALU_ADD;   // Base plus offset
                ctrl_o.mem_op     = funct3;
            end
            STORE: begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.alu_ctrl  = ALU_ADD;
                ctrl_o.mem_op    = funct3;
            end
            BRANCH: begin
                ctrl_o.branch   = branch_decode(funct3);
                ctrl_o.alu_ctrl = ALU_SUB;   // Compare by subtraction
            end
            JAL: begin
                ctrl_o.jump       = 1'b1;
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.result_src = RES_PC4;
            end
            JALR: begin
                ctrl_o.jump       = 1'b1;
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.result_src = RES_PC4;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.alu_ctrl   = ALU_ADD;
            end
            LUI: begin
                ctrl_o.upper_op  = UP_LUI;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
            end
            AUIPC: begin
                ctrl_o.upper_op  = UP_AUIPC;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
            end
            default: ctrl_o = '0;   // Bubble
        endcase
    end

    // Codes 10 to 15 would reach the ALU undecoded
    always_comb begin
        assert (ctrl_o.alu_ctrl inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU})
            else $error("control_unit: illegal alu_ctrl %0h", ctrl_o.alu_ctrl);
    end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module regfile import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  logic      we_i,
    input  reg_addr_t rd_i,
    input  word_t     wd_i,
    output word_t     rd1_o,
    output word_t     rd2_o
);

    word_t regs [1:`RV_NREGS-1];   // No storage for x0

    logic wr_live;

    assign wr_live = we_i && (rd_i != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_i] <= wd_i;
        end
    end

    // Writeback bypass gives write-before-read in one cycle
    assign rd1_o = (rs1_i == '0)                 ? '0   :
                   (wr_live && (rd_i == rs1_i)) ? wd_i :
                                                   regs[rs1_i];
    assign rd2_o = (rs2_i == '0)                 ? '0   :
                   (wr_live && (rd_i == rs2_i)) ? wd_i :
                                                   regs[rs2_i];

    // x0 stays zero even with a writeback to x0 in flight
    assert property (@(posedge clk) disable iff (reset_i)
        (rs1_i == '0) |-> (rd1_o == '0))
        else $error("regfile: x0 read on port 1 returned %0h", rd1_o);

    assert property (@(posedge clk) disable iff (reset_i)
        (rs2_i == '0) |-> (rd2_o == '0))
        else $error("regfile: x0 read on port 2 returned %0h", rd2_o);

endmodule

`default_nettype wire

// ==== hdl/imm_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module imm_extend import rv_isa_pkg::*; (
    input  instr_t instr_i,
    output word_t  imm_o
);

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    imm_fmt_e fmt;
    logic     sign;

    assign sign = instr_i[31];   // Sign bit sits at [31] in every format

    always_comb begin
        case (opcode_e'(instr_i[6:0]))
            LOAD, OP_IMM, JALR: fmt = IMM_I;
            STORE:              fmt = IMM_S;
            BRANCH:             fmt = IMM_B;
            LUI, AUIPC:         fmt = IMM_U;
            JAL:                fmt = IMM_J;
            default:            fmt = IMM_NONE;
        endcase
    end

    always_comb begin
        case (fmt)
            IMM_I:   imm_o = {{(`RV_XLEN-12){sign}}, instr_i[31:20]};
            IMM_S:   imm_o = {{(`RV_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            IMM_B:   imm_o = {{(`RV_XLEN-13){sign}}, instr_i[31], instr_i[7],
                              instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_U:   imm_o = {instr_i[31:12], 12'b0};
            IMM_J:   imm_o = {{(`RV_XLEN-21){sign}}, instr_i[31], instr_i[19:12],
                              instr_i[20], instr_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/decode_pipeline_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_pipeline_regfile import rv_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      stall_i,
    input  logic      flush_i,
    input  de_stage_t de_i,
    output de_stage_t de_o
);

    // Flush beats stall so a squashed instruction never lingers
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            de_o <= '0;   // Bubble
        end else if (!stall_i) begin
            de_o <= de_i;
        end
    end

    // A bubble must never write the register file
    assert property (@(posedge clk)
        (reset_i || flush_i) |=> !de_o.ctrl.reg_write)
        else $error("decode_pipeline_regfile: reg_write set after reset or flush");

    // Held bundle stays put through a stall
    assert property (@(posedge clk) disable iff (reset_i)
        (stall_i && !flush_i) |=> $stable(de_o))
        else $error("decode_pipeline_regfile: de_o changed during stall");

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  instr_t    instr_i,
    input  word_t     pc_i,
    input  word_t     pc_plus4_i,
    input  logic      stall_i,
    input  logic      flush_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,
    output de_stage_t de_o
);

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    ctrl_t     ctrl;
    word_t     rd1;
    word_t     rd2;
    word_t     imm_ext;
    de_stage_t de_d;

    // Register fields sit at the same place in every format
    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];
    assign rd  = instr_i[11:7];

    control_unit control_unit_inst (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    regfile regfile_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .we_i    (wb_we_i),
        .rd_i    (wb_rd_i),
        .wd_i    (wb_data_i),
        .rd1_o   (rd1),
        .rd2_o   (rd2)
    );

    imm_extend imm_extend_inst (
        .instr_i (instr_i),
        .imm_o   (imm_ext)
    );

    always_comb begin
        de_d.ctrl     = ctrl;
        de_d.rd1      = rd1;
        de_d.rd2      = rd2;
        de_d.pc       = pc_i;
        de_d.rs1      = rs1;
        de_d.rs2      = rs2;
        de_d.rd       = rd;
        de_d.imm_ext  = imm_ext;
        de_d.pc_plus4 = pc_plus4_i;   // Taken from fetch, not recomputed
    end

    decode_pipeline_regfile decode_pipeline_regfile_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .de_i    (de_d),
        .de_o    (de_o)
    );

endmodule

`default_nettype wire

// ==== dv/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module tb_decode_stage import rv_isa_pkg::*, rv_pipe_pkg::*; ();

    localparam int MAX_CYCLES = 2000;   // Wide margin over about 160 test cycles

    logic      clk = 1'b0;
    logic      reset_i;
    logic      stall_i;
    logic      flush_i;
    logic      wb_we_i;
    instr_t    instr_i;
    word_t     pc_i;
    word_t     pc_plus4_i;
    reg_addr_t wb_rd_i;
    word_t     wb_data_i;
    de_stage_t de_o;

    word_t       shadow [`RV_NREGS];   // Expected register file contents
    de_stage_t   held;                 // Last expected bundle, kept for stall
    logic [15:0] lfsr_state = 16'd46279;
    int          cycles = 0;

    decode_stage decode_stage_inst (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests never finished", cycles);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // Taps 16, 14, 13, 11
    function automatic word_t take_bits(input int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Control from the decode rule table, keyed by raw opcode bits
    function automatic ctrl_t ref_ctrl(input instr_t ins);
        ctrl_t      c;
        logic [2:0] f3;
        logic       r_alu, i_alu, load, store, branch, jal, jalr, lui, auipc;
        f3    = ins[14:12];
        r_alu = ins[6:0] == 7'b0110011;
        i_alu = ins[6:0] == 7'b0010011;
        load  = ins[6:0] == 7'b0000011;
        store = ins[6:0] == 7'b0100011;
        branch = ins[6:0] == 7'b1100011;
        jal   = ins[6:0] == 7'b1101111;
        jalr  = ins[6:0] == 7'b1100111;
        lui   = ins[6:0] == 7'b0110111;
        auipc = ins[6:0] == 7'b0010111;
        c = '0;
        c.reg_write  = r_alu | i_alu | load | jal | jalr | lui | auipc;
        c.mem_write  = store;
        c.jump       = jal | jalr;
        c.alu_src    = i_alu | load | store | jalr | lui | auipc;
        c.result_src = load ? RES_MEM : (jal | jalr) ? RES_PC4 : RES_ALU;
        c.upper_op   = lui ? UP_LUI : auipc ? UP_AUIPC : UP_NONE;
        c.mem_op     = (load | store) ? f3 : 3'b000;
        if (branch) begin
            c.alu_ctrl = ALU_SUB;
            case (f3)
                3'b000:  c.branch = BR_EQ;
                3'b001:  c.branch = BR_NE;
                3'b100:  c.branch = BR_LT;
                3'b101:  c.branch = BR_GE;
                3'b110:  c.branch = BR_LTU;
                3'b111:  c.branch = BR_GEU;
                default: c.branch = BR_NONE;
            endcase
        end else if (r_alu | i_alu) begin
            case (f3)   // ins[30] is funct7 bit 5
                3'b000:  c.alu_ctrl = (r_alu && ins[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  c.alu_ctrl = ALU_SLL;
                3'b010:  c.alu_ctrl = ALU_SLT;
                3'b011:  c.alu_ctrl = ALU_SLTU;
                3'b100:  c.alu_ctrl = ALU_XOR;
                3'b101:  c.alu_ctrl = ins[30] ? ALU_SRA : ALU_SRL;
                3'b110:  c.alu_ctrl = ALU_OR;
                default: c.alu_ctrl = ALU_AND;
            endcase
        end
        return c;
    endfunction

    function automatic word_t ref_imm(input instr_t ins);
        case (ins[6:0])
            7'b0000011, 7'b0010011, 7'b1100111: return {{20{ins[31]}}, ins[31:20]};
            7'b0100011: return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            7'b1100011: return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            7'b0110111, 7'b0010111: return {ins[31:12], 12'h000};
            7'b1101111: return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    // Same-cycle writeback wins over the stored value
    function automatic word_t expected_read(input reg_addr_t a);
        if (a == '0) return '0;
        if (wb_we_i && (wb_rd_i == a)) return wb_data_i;
        return shadow[a];
    endfunction

    function automatic instr_t rand_instr(input logic [6:0] op, input logic [2:0] f3);
        word_t r;
        r = take_bits(25);
        return {r[24:8], f3, r[4:0], op};
    endfunction

    task automatic check_field(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic compare_bundle(input de_stage_t exp);
        check_field("ctrl",     {14'b0, exp.ctrl}, {14'b0, de_o.ctrl});
        check_field("rd1",      exp.rd1,           de_o.rd1);
        check_field("rd2",      exp.rd2,           de_o.rd2);
        check_field("pc",       exp.pc,            de_o.pc);
        check_field("rs1",      {27'b0, exp.rs1},  {27'b0, de_o.rs1});
        check_field("rs2",      {27'b0, exp.rs2},  {27'b0, de_o.rs2});
        check_field("rd",       {27'b0, exp.rd},   {27'b0, de_o.rd});
        check_field("imm_ext",  exp.imm_ext,       de_o.imm_ext);
        check_field("pc_plus4", exp.pc_plus4,      de_o.pc_plus4);
    endtask

    // Entered 2 ns after a rising edge, returns 2 ns after the next one
    task automatic decode_check(input instr_t ins, input word_t pc, input logic we,
                                input reg_addr_t wrd, input word_t wdata);
        de_stage_t exp;
        instr_i    = ins;
        pc_i       = pc;
        pc_plus4_i = pc + 32'd4;
        wb_we_i    = we;
        wb_rd_i    = wrd;
        wb_data_i  = wdata;
        exp.ctrl     = ref_ctrl(ins);
        exp.rd1      = expected_read(ins[19:15]);
        exp.rd2      = expected_read(ins[24:20]);
        exp.pc       = pc;
        exp.rs1      = ins[19:15];
        exp.rs2      = ins[24:20];
        exp.rd       = ins[11:7];
        exp.imm_ext  = ref_imm(ins);
        exp.pc_plus4 = pc + 32'd4;
        if (flush_i) begin
            exp = '0;
        end else if (stall_i) begin
            exp = held;
        end
        @(posedge clk);
        if (we && (wrd != '0)) begin
            shadow[wrd] = wdata;
        end
        #1;
        compare_bundle(exp);
        held = exp;
        #1;
    endtask

    task automatic decode_only(input instr_t ins);
        decode_check(ins, take_bits(30) << 2, 1'b0, '0, '0);
    endtask

    task automatic reset_test();
        compare_bundle('0);
        decode_only(rand_instr(7'b0110011, 3'b000));   // Cleared registers read zero
    endtask

    task automatic regfile_alu_test();
        instr_t ins;
        for (int r = 0; r < `RV_NREGS; r++) begin
            decode_check('0, '0, 1'b1, reg_addr_t'(r), take_bits(32));
        end
        // x0 with a write to it in flight
        ins = {7'd0, 5'd0, 5'd0, 3'b000, 5'd3, 7'b0110011};
        decode_check(ins, 32'h100, 1'b1, '0, take_bits(32));
        for (int f = 0; f < 8; f++) begin
            repeat (3) begin
                decode_only(rand_instr(7'b0110011, 3'(f)));
                decode_only(rand_instr(7'b0010011, 3'(f)));
            end
        end
    endtask

    task automatic control_test();
        for (int f = 0; f < 8; f++) begin
            decode_only(rand_instr(7'b0000011, 3'(f)));
            decode_only(rand_instr(7'b0100011, 3'(f)));
            decode_only(rand_instr(7'b1100011, 3'(f)));
        end
        repeat (6) begin
            decode_only(rand_instr(7'b1101111, 3'(take_bits(3))));
            decode_only(rand_instr(7'b1100111, 3'b000));
            decode_only(rand_instr(7'b0110111, 3'(take_bits(3))));
            decode_only(rand_instr(7'b0010111, 3'(take_bits(3))));
        end
    endtask

    task automatic bypass_test();
        instr_t ins;
        repeat (8) begin
            ins = rand_instr(7'b0110011, 3'(take_bits(3)));
            if (ins[19:15] == '0) begin
                ins[19:15] = 5'd9;
            end
            decode_check(ins, take_bits(30) << 2, 1'b1, ins[19:15], take_bits(32));
        end
    endtask

    task automatic stall_flush_test();
        decode_only(rand_instr(7'b0110011, 3'b000));
        stall_i = 1'b1;
        decode_only(rand_instr(7'b0000011, 3'b010));
        decode_only(rand_instr(7'b1101111, 3'b000));
        stall_i = 1'b0;
        flush_i = 1'b1;
        decode_only(rand_instr(7'b0010011, 3'b001));
        flush_i = 1'b0;
        decode_only(rand_instr(7'b0100011, 3'b010));
        stall_i = 1'b1;
        flush_i = 1'b1;   // Flush takes priority
        decode_only(rand_instr(7'b1100011, 3'b001));
        stall_i = 1'b0;
        flush_i = 1'b0;
        decode_only(rand_instr(7'b0110111, 3'b000));
    endtask

    task automatic unknown_opcode_test();
        logic [6:0] bad_ops [5];
        bad_ops = '{7'b0001111, 7'b1110011, 7'b0000000, 7'b1111111, 7'b0101111};
        foreach (bad_ops[k]) begin
            decode_only(rand_instr(bad_ops[k], 3'(take_bits(3))));
        end
    endtask

    initial begin
        reset_i    = 1'b1;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        wb_we_i    = 1'b0;
        instr_i    = '0;
        pc_i       = '0;
        pc_plus4_i = '0;
        wb_rd_i    = '0;
        wb_data_i  = '0;
        held       = '0;
        for (int r = 0; r < `RV_NREGS; r++) begin
            shadow[r] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        reset_i = 1'b0;
        reset_test();
        regfile_alu_test();
        control_test();
        bypass_test();
        stall_flush_test();
        unknown_opcode_test();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/control_unit.sv
hdl/regfile.sv
hdl/imm_extend.sv
hdl/decode_pipeline_regfile.sv
hdl/decode_stage.sv
dv/tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_decode_stage \
    -Mdir obj_dir -o sim_decode_stage \
    && ./obj_dir/sim_decode_stage \
    || { echo "build or run returned an error"; exit 1; }
